// ==== Bender.yml ====
package:
  name: ex_core

sources:
  - hdl/cpu_pkg.sv
  - hdl/stage_result_if.sv
  - hdl/ex.sv
  - hdl/result_reg.sv
  - hdl/hilo_reg.sv
  - hdl/cp0_regs.sv
  - hdl/ex_core.sv
  - target: test
    files:
      - tests/ex_core_chk.sv
      - tests/ex_core_tb.sv

// ==== ex_core.f ====
hdl/cpu_pkg.sv
hdl/stage_result_if.sv
hdl/ex.sv
hdl/result_reg.sv
hdl/hilo_reg.sv
hdl/cp0_regs.sv
hdl/ex_core.sv
tests/ex_core_chk.sv
tests/ex_core_tb.sv

// ==== hdl/cp0_regs.sv ====
module cp0_regs (
    input  logic               clk_i,
    input  logic               arst_n_i,
    stage_result_if.dst        wb,
    input  cpu_pkg::reg_addr_t raddr_i,
    output cpu_pkg::word_t     rdata_o
);

    cpu_pkg::word_t status;
    cpu_pkg::word_t cause;
    cpu_pkg::word_t epc;

    // commit from write-back
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            status <= cpu_pkg::ZERO_WORD;
            cause  <= cpu_pkg::ZERO_WORD;
            epc    <= cpu_pkg::ZERO_WORD;
        end else if (wb.cp0_we) begin
            case (wb.cp0_addr)
                cpu_pkg::CP0_STATUS: status <= wb.cp0_data;
                cpu_pkg::CP0_CAUSE:  cause  <= wb.cp0_data;
                cpu_pkg::CP0_EPC:    epc    <= wb.cp0_data;
                default: ;
            endcase
        end
    end

    // unimplemented registers read as zero
    always_comb begin
        case (raddr_i)
            cpu_pkg::CP0_STATUS: rdata_o = status;
            cpu_pkg::CP0_CAUSE:  rdata_o = cause;
            cpu_pkg::CP0_EPC:    rdata_o = epc;
            default:             rdata_o = cpu_pkg::ZERO_WORD;
        endcase
    end

endmodule

// ==== hdl/cpu_pkg.sv ====
package cpu_pkg;

    // datapath widths
    localparam int WORD_W     = 32;
    localparam int DWORD_W    = 64;
    localparam int REG_ADDR_W = 5;
    localparam int OPER_W     = 5;

    typedef logic [WORD_W-1:0]     word_t;
    typedef logic [DWORD_W-1:0]    dword_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    // immediate forms are folded into these by decode
    typedef enum logic [OPER_W-1:0] {
        OP_NOP,
        OP_AND, OP_OR, OP_XOR, OP_NOR,
        OP_SLL, OP_SRL, OP_SRA, OP_LUI,
        OP_MOVN, OP_MOVZ,
        OP_MFHI, OP_MFLO, OP_MTHI, OP_MTLO,
        OP_ADDU, OP_SUBU, OP_SLT, OP_SLTU,
        OP_MUL, OP_MULT, OP_MULTU,
        OP_JAL, OP_JALR,
        OP_LW, OP_SW,
        OP_MTC0, OP_MFC0
    } oper_t;

    // cp0 register numbers
    localparam reg_addr_t CP0_STATUS = 5'd12;
    localparam reg_addr_t CP0_CAUSE  = 5'd13;
    localparam reg_addr_t CP0_EPC    = 5'd14;

    // link register for jal
    localparam reg_addr_t REG_RA = 5'd31;

    localparam word_t ZERO_WORD = '0;

    // return address skips the delay slot
    localparam word_t LINK_OFFSET = 32'd8;

endpackage

// ==== hdl/ex.sv ====
module ex (
    input  cpu_pkg::word_t     pc_i,
    input  cpu_pkg::oper_t     oper_i,
    input  cpu_pkg::word_t     reg1_i,
    input  cpu_pkg::word_t     reg2_i,
    input  logic               wreg_write_i,
    input  cpu_pkg::reg_addr_t wreg_addr_i,
    input  cpu_pkg::word_t     hi_i,
    input  cpu_pkg::word_t     lo_i,
    input  cpu_pkg::word_t     cp0_data_i,
    output cpu_pkg::reg_addr_t cp0_raddr_o,
    stage_result_if.dst        mem_fwd,
    stage_result_if.dst        wb_fwd,
    stage_result_if.src        res
);

    cpu_pkg::word_t  hi_fwd;
    cpu_pkg::word_t  lo_fwd;
    cpu_pkg::word_t  cp0_fwd;
    cpu_pkg::word_t  add_res;
    cpu_pkg::word_t  sub_res;
    logic            signed_lt;
    logic            unsigned_lt;
    logic            is_signed;
    logic            res_sign;
    cpu_pkg::word_t  abs_reg1;
    cpu_pkg::word_t  abs_reg2;
    cpu_pkg::dword_t mul_abs;
    cpu_pkg::dword_t mul_res;

    // cp0 index comes from the rt operand
    assign cp0_raddr_o = reg2_i[cpu_pkg::REG_ADDR_W-1:0];

    // newest hi/lo wins, mem before wb before committed
    always_comb begin
        if (mem_fwd.whilo) begin
            {hi_fwd, lo_fwd} = {mem_fwd.hi, mem_fwd.lo};
        end else if (wb_fwd.whilo) begin
            {hi_fwd, lo_fwd} = {wb_fwd.hi, wb_fwd.lo};
        end else begin
            {hi_fwd, lo_fwd} = {hi_i, lo_i};
        end
    end

    always_comb begin
        if (mem_fwd.cp0_we && mem_fwd.cp0_addr == cp0_raddr_o) begin
            cp0_fwd = mem_fwd.cp0_data;
        end else if (wb_fwd.cp0_we && wb_fwd.cp0_addr == cp0_raddr_o) begin
            cp0_fwd = wb_fwd.cp0_data;
        end else begin
            cp0_fwd = cp0_data_i;
        end
    end

    assign add_res = reg1_i + reg2_i;
    assign sub_res = reg1_i - reg2_i;

    // differing signs decide directly, else the difference sign does
    assign signed_lt   = (reg1_i[31] != reg2_i[31]) ? reg1_i[31] : sub_res[31];
    assign unsigned_lt = (reg1_i < reg2_i);

    // multiply magnitudes, then put the sign back
    assign is_signed = (oper_i != cpu_pkg::OP_MULTU);
    assign res_sign  = is_signed && (reg1_i[31] ^ reg2_i[31]);
    assign abs_reg1  = (is_signed && reg1_i[31]) ? -reg1_i : reg1_i;
    assign abs_reg2  = (is_signed && reg2_i[31]) ? -reg2_i : reg2_i;
    assign mul_abs   = cpu_pkg::dword_t'(abs_reg1) * cpu_pkg::dword_t'(abs_reg2);
    assign mul_res   = res_sign ? -mul_abs : mul_abs;

    always_comb begin
        res.oper       = oper_i;
        res.wreg_write = wreg_write_i;
        res.wreg_addr  = wreg_addr_i;
        res.wreg_data  = cpu_pkg::ZERO_WORD;
        res.whilo      = 1'b0;
        res.hi         = hi_fwd;
        res.lo         = lo_fwd;
        res.cp0_we     = 1'b0;
        res.cp0_addr   = '0;
        res.cp0_data   = cpu_pkg::ZERO_WORD;
        res.mem_addr   = cpu_pkg::ZERO_WORD;
        res.mem_data   = cpu_pkg::ZERO_WORD;

        case (oper_i)
            cpu_pkg::OP_AND:  res.wreg_data = reg1_i & reg2_i;
            cpu_pkg::OP_OR:   res.wreg_data = reg1_i | reg2_i;
            cpu_pkg::OP_XOR:  res.wreg_data = reg1_i ^ reg2_i;
            cpu_pkg::OP_NOR:  res.wreg_data = ~(reg1_i | reg2_i);
            // shift amount in reg1, value in reg2
            cpu_pkg::OP_SLL:  res.wreg_data = reg2_i << reg1_i[4:0];
            cpu_pkg::OP_SRL:  res.wreg_data = reg2_i >> reg1_i[4:0];
            cpu_pkg::OP_SRA:  res.wreg_data = $signed(reg2_i) >>> reg1_i[4:0];
            cpu_pkg::OP_LUI:  res.wreg_data = {reg2_i[15:0], 16'b0};
            cpu_pkg::OP_MOVN: begin
                res.wreg_data  = reg1_i;
                res.wreg_write = wreg_write_i && (reg2_i != cpu_pkg::ZERO_WORD);
            end
            cpu_pkg::OP_MOVZ: begin
                res.wreg_data  = reg1_i;
                res.wreg_write = wreg_write_i && (reg2_i == cpu_pkg::ZERO_WORD);
            end
            cpu_pkg::OP_MFHI: res.wreg_data = hi_fwd;
            cpu_pkg::OP_MFLO: res.wreg_data = lo_fwd;
            cpu_pkg::OP_MTHI: begin
                res.wreg_write = 1'b0;
                res.whilo      = 1'b1;
                res.hi         = reg1_i;
            end
            cpu_pkg::OP_MTLO: begin
                res.wreg_write = 1'b0;
                res.whilo      = 1'b1;
                res.lo         = reg1_i;
            end
            cpu_pkg::OP_ADDU: res.wreg_data = add_res;
            cpu_pkg::OP_SUBU: res.wreg_data = sub_res;
            cpu_pkg::OP_SLT:  res.wreg_data = {31'b0, signed_lt};
            cpu_pkg::OP_SLTU: res.wreg_data = {31'b0, unsigned_lt};
            cpu_pkg::OP_MUL:  res.wreg_data = mul_res[cpu_pkg::WORD_W-1:0];
            cpu_pkg::OP_MULT, cpu_pkg::OP_MULTU: begin
                res.wreg_write   = 1'b0;
                res.whilo        = 1'b1;
                {res.hi, res.lo} = mul_res;
            end
            // jal always links into ra
            cpu_pkg::OP_JAL: begin
                res.wreg_write = 1'b1;
                res.wreg_addr  = cpu_pkg::REG_RA;
                res.wreg_data  = pc_i + cpu_pkg::LINK_OFFSET;
            end
            cpu_pkg::OP_JALR: res.wreg_data = pc_i + cpu_pkg::LINK_OFFSET;
            cpu_pkg::OP_LW:   res.mem_addr = add_res;
            cpu_pkg::OP_SW: begin
                res.wreg_write = 1'b0;
                res.mem_addr   = reg1_i;
                res.mem_data   = reg2_i;
            end
            cpu_pkg::OP_MTC0: begin
                res.wreg_write = 1'b0;
                res.cp0_we     = 1'b1;
                res.cp0_addr   = cp0_raddr_o;
                res.cp0_data   = reg1_i;
            end
            cpu_pkg::OP_MFC0: res.wreg_data = cp0_fwd;
            // bubbles never write
            default: res.wreg_write = 1'b0;
        endcase
    end

endmodule

// ==== hdl/ex_core.sv ====
module ex_core (
    input  logic               clk_i,
    input  logic               arst_n_i,
    input  cpu_pkg::word_t     pc_i,
    input  cpu_pkg::oper_t     oper_i,
    input  cpu_pkg::word_t     reg1_i,
    input  cpu_pkg::word_t     reg2_i,
    input  logic               wreg_write_i,
    input  cpu_pkg::reg_addr_t wreg_addr_i,
    output cpu_pkg::oper_t     mem_oper_o,
    output cpu_pkg::word_t     mem_addr_o,
    output cpu_pkg::word_t     mem_data_o,
    output logic               wb_write_o,
    output cpu_pkg::reg_addr_t wb_addr_o,
    output cpu_pkg::word_t     wb_data_o
);

    cpu_pkg::word_t     hi;
    cpu_pkg::word_t     lo;
    cpu_pkg::reg_addr_t cp0_raddr;
    cpu_pkg::word_t     cp0_rdata;

    stage_result_if ex_res ();
    stage_result_if mem_res ();
    stage_result_if wb_res ();

    ex u_ex (
        .pc_i         (pc_i),
        .oper_i       (oper_i),
        .reg1_i       (reg1_i),
        .reg2_i       (reg2_i),
        .wreg_write_i (wreg_write_i),
        .wreg_addr_i  (wreg_addr_i),
        .hi_i         (hi),
        .lo_i         (lo),
        .cp0_data_i   (cp0_rdata),
        .cp0_raddr_o  (cp0_raddr),
        .mem_fwd      (mem_res.dst),
        .wb_fwd       (wb_res.dst),
        .res          (ex_res.src)
    );

    result_reg u_ex_mem (.clk_i(clk_i), .arst_n_i(arst_n_i), .d(ex_res.dst), .q(mem_res.src));
    result_reg u_mem_wb (.clk_i(clk_i), .arst_n_i(arst_n_i), .d(mem_res.dst), .q(wb_res.src));

    hilo_reg u_hilo (.clk_i(clk_i), .arst_n_i(arst_n_i), .wb(wb_res.dst), .hi_o(hi), .lo_o(lo));

    cp0_regs u_cp0 (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .wb       (wb_res.dst),
        .raddr_i  (cp0_raddr),
        .rdata_o  (cp0_rdata)
    );

    // memory request leaves from the ex/mem register
    assign mem_oper_o = mem_res.oper;
    assign mem_addr_o = mem_res.mem_addr;
    assign mem_data_o = mem_res.mem_data;

    assign wb_write_o = wb_res.wreg_write;
    assign wb_addr_o  = wb_res.wreg_addr;
    assign wb_data_o  = wb_res.wreg_data;

endmodule

// ==== hdl/hilo_reg.sv ====
module hilo_reg (
    input  logic           clk_i,
    input  logic           arst_n_i,
    stage_result_if.dst    wb,
    output cpu_pkg::word_t hi_o,
    output cpu_pkg::word_t lo_o
);

    // both halves load together, mthi/mtlo carry the other half along
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            hi_o <= cpu_pkg::ZERO_WORD;
            lo_o <= cpu_pkg::ZERO_WORD;
        end else if (wb.whilo) begin
            hi_o <= wb.hi;
            lo_o <= wb.lo;
        end
    end

endmodule

// ==== hdl/result_reg.sv ====
module result_reg (
    input  logic        clk_i,
    input  logic        arst_n_i,
    stage_result_if.dst d,
    stage_result_if.src q
);

    // write flags and opcode
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            q.wreg_write <= 1'b0;
            q.whilo      <= 1'b0;
            q.cp0_we     <= 1'b0;
            q.oper       <= cpu_pkg::OP_NOP;
        end else begin
            q.wreg_write <= d.wreg_write;
            q.whilo      <= d.whilo;
            q.cp0_we     <= d.cp0_we;
            q.oper       <= d.oper;
        end
    end

    // payload only matters while a flag is set
    always_ff @(posedge clk_i) begin
        q.wreg_addr <= d.wreg_addr;
        q.wreg_data <= d.wreg_data;
        q.hi        <= d.hi;
        q.lo        <= d.lo;
        q.cp0_addr  <= d.cp0_addr;
        q.cp0_data  <= d.cp0_data;
        q.mem_addr  <= d.mem_addr;
        q.mem_data  <= d.mem_data;
    end

endmodule

// ==== hdl/stage_result_if.sv ====
interface stage_result_if;

    // general register write
    logic               wreg_write;
    cpu_pkg::reg_addr_t wreg_addr;
    cpu_pkg::word_t     wreg_data;

    // hi/lo pair
    logic               whilo;
    cpu_pkg::word_t     hi;
    cpu_pkg::word_t     lo;

    // coprocessor 0
    logic               cp0_we;
    cpu_pkg::reg_addr_t cp0_addr;
    cpu_pkg::word_t     cp0_data;

    // memory request, oper also marks bubbles
    cpu_pkg::oper_t     oper;
    cpu_pkg::word_t     mem_addr;
    cpu_pkg::word_t     mem_data;

    modport src (
        output wreg_write, wreg_addr, wreg_data,
        output whilo, hi, lo,
        output cp0_we, cp0_addr, cp0_data,
        output oper, mem_addr, mem_data
    );

    modport dst (
        input wreg_write, wreg_addr, wreg_data,
        input whilo, hi, lo,
        input cp0_we, cp0_addr, cp0_data,
        input oper, mem_addr, mem_data
    );

endinterface

// ==== tests/ex_core_chk.sv ====
module ex_core_chk (
    input logic           clk_i,
    input logic           arst_n_i,
    input cpu_pkg::oper_t oper_i,
    // bit order is wreg_write, whilo, cp0_we
    input logic [2:0]     mem_flags_i,
    input logic [2:0]     wb_flags_i
);

    logic seen_op;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            seen_op <= 1'b0;
        end else if (oper_i != cpu_pkg::OP_NOP) begin
            seen_op <= 1'b1;
        end
    end

    // pipeline stays quiet until a real operation enters
    quiet_after_reset: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        !seen_op |-> (mem_flags_i == 3'b000 && wb_flags_i == 3'b000))
        else $error("write flag set before any operation entered execute");

    hilo_excl: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        !(mem_flags_i[2] && mem_flags_i[1]) && !(wb_flags_i[2] && wb_flags_i[1]))
        else $error("whilo and wreg_write set together");

    cp0_excl: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        !(mem_flags_i[2] && mem_flags_i[0]) && !(wb_flags_i[2] && wb_flags_i[0]))
        else $error("cp0_we and wreg_write set together");

endmodule

bind ex_core ex_core_chk u_chk (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .oper_i      (oper_i),
    .mem_flags_i ({mem_res.wreg_write, mem_res.whilo, mem_res.cp0_we}),
    .wb_flags_i  ({wb_res.wreg_write, wb_res.whilo, wb_res.cp0_we})
);

// ==== tests/ex_core_tb.sv ====
module ex_core_tb;

    // one table row: stimulus followed by the expected results
    typedef struct packed {
        cpu_pkg::oper_t     oper;
        cpu_pkg::word_t     pc;
        cpu_pkg::word_t     reg1;
        cpu_pkg::word_t     reg2;
        logic               wreg_write;
        cpu_pkg::reg_addr_t wreg_addr;
        logic               exp_write;
        cpu_pkg::reg_addr_t exp_addr;
        cpu_pkg::word_t     exp_data;
        cpu_pkg::word_t     exp_mem_addr;
        cpu_pkg::word_t     exp_mem_data;
    } row_t;

    logic               clk_i;
    logic               arst_n_i;
    cpu_pkg::word_t     pc_i;
    cpu_pkg::oper_t     oper_i;
    cpu_pkg::word_t     reg1_i;
    cpu_pkg::word_t     reg2_i;
    logic               wreg_write_i;
    cpu_pkg::reg_addr_t wreg_addr_i;
    cpu_pkg::oper_t     mem_oper_o;
    cpu_pkg::word_t     mem_addr_o;
    cpu_pkg::word_t     mem_data_o;
    logic               wb_write_o;
    cpu_pkg::reg_addr_t wb_addr_o;
    cpu_pkg::word_t     wb_data_o;

    row_t           rows [$];
    cpu_pkg::word_t rng_state = 32'ha0572054;
    cpu_pkg::word_t hi_m = '0;
    cpu_pkg::word_t lo_m = '0;
    // status, cause, epc in program order
    cpu_pkg::word_t cp0_m [3] = '{default: '0};
    int             cycles = 0;

    ex_core u_ex_core (.*);

    initial begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;
    end

    function automatic cpu_pkg::word_t xorshift32(input cpu_pkg::word_t s);
        cpu_pkg::word_t x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function cpu_pkg::word_t rand_word();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        if (act !== exp) begin
            $display("MISMATCH at %0t: %s expected %h, got %h", $time, name, exp, act);
            $display("SIMULATION FAILED");
            $fatal(1);
        end
    endtask

    // reference model updated in program order
    task automatic add_row(input cpu_pkg::oper_t op, input cpu_pkg::word_t pc,
                           input cpu_pkg::word_t a, input cpu_pkg::word_t b,
                           input logic w, input cpu_pkg::reg_addr_t wa);
        row_t            r;
        cpu_pkg::dword_t smul;
        cpu_pkg::dword_t umul;
        cpu_pkg::word_t  wd;
        cpu_pkg::word_t  ma;
        cpu_pkg::word_t  md;
        r = '{oper: op, pc: pc, reg1: a, reg2: b, wreg_write: w, wreg_addr: wa, default: '0};
        smul = $signed({{32{a[31]}}, a}) * $signed({{32{b[31]}}, b});
        umul = {32'h0, a} * {32'h0, b};
        wd = '0;
        ma = '0;
        md = '0;
        case (op)
            cpu_pkg::OP_AND:   wd = a & b;
            cpu_pkg::OP_OR:    wd = a | b;
            cpu_pkg::OP_XOR:   wd = a ^ b;
            cpu_pkg::OP_NOR:   wd = ~(a | b);
            cpu_pkg::OP_SLL:   wd = b << a[4:0];
            cpu_pkg::OP_SRL:   wd = b >> a[4:0];
            cpu_pkg::OP_SRA:   wd = $signed(b) >>> a[4:0];
            cpu_pkg::OP_LUI:   wd = {b[15:0], 16'h0};
            cpu_pkg::OP_MOVN:  {w, wd} = {w && (b != '0), a};
            cpu_pkg::OP_MOVZ:  {w, wd} = {w && (b == '0), a};
            cpu_pkg::OP_MFHI:  wd = hi_m;
            cpu_pkg::OP_MFLO:  wd = lo_m;
            cpu_pkg::OP_MTHI:  hi_m = a;
            cpu_pkg::OP_MTLO:  lo_m = a;
            cpu_pkg::OP_ADDU:  wd = a + b;
            cpu_pkg::OP_SUBU:  wd = a - b;
            cpu_pkg::OP_SLT:   wd = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            cpu_pkg::OP_SLTU:  wd = (a < b) ? 32'd1 : 32'd0;
            cpu_pkg::OP_MUL:   wd = smul[31:0];
            cpu_pkg::OP_MULT:  {hi_m, lo_m} = smul;
            cpu_pkg::OP_MULTU: {hi_m, lo_m} = umul;
            cpu_pkg::OP_JAL:   {w, wa, wd} = {1'b1, cpu_pkg::REG_RA, pc + 32'd8};
            cpu_pkg::OP_JALR:  wd = pc + 32'd8;
            cpu_pkg::OP_LW:    ma = a + b;
            cpu_pkg::OP_SW:    {ma, md} = {a, b};
            cpu_pkg::OP_MTC0: begin
                if (b[4:0] >= cpu_pkg::CP0_STATUS && b[4:0] <= cpu_pkg::CP0_EPC) begin
                    cp0_m[b[4:0] - cpu_pkg::CP0_STATUS] = a;
                end
            end
            cpu_pkg::OP_MFC0: begin
                if (b[4:0] >= cpu_pkg::CP0_STATUS && b[4:0] <= cpu_pkg::CP0_EPC) begin
                    wd = cp0_m[b[4:0] - cpu_pkg::CP0_STATUS];
                end
            end
            default: ;
        endcase
        // these never write a general register
        case (op)
            cpu_pkg::OP_NOP, cpu_pkg::OP_MTHI, cpu_pkg::OP_MTLO, cpu_pkg::OP_MULT,
            cpu_pkg::OP_MULTU, cpu_pkg::OP_MTC0, cpu_pkg::OP_SW: w = 1'b0;
            default: ;
        endcase
        r.exp_write    = w;
        r.exp_addr     = wa;
        r.exp_data     = wd;
        r.exp_mem_addr = ma;
        r.exp_mem_data = md;
        rows.push_back(r);
    endtask

    task automatic build_table();
        cpu_pkg::oper_t alu_ops [12];
        alu_ops = '{cpu_pkg::OP_AND, cpu_pkg::OP_OR, cpu_pkg::OP_XOR, cpu_pkg::OP_NOR,
                    cpu_pkg::OP_SLL, cpu_pkg::OP_SRL, cpu_pkg::OP_SRA, cpu_pkg::OP_LUI,
                    cpu_pkg::OP_ADDU, cpu_pkg::OP_SUBU, cpu_pkg::OP_SLT, cpu_pkg::OP_SLTU};
        // bubbles right after reset carry a set write flag
        add_row(cpu_pkg::OP_NOP, rand_word(), rand_word(), rand_word(), 1'b1, 5'd3);
        add_row(cpu_pkg::OP_NOP, rand_word(), rand_word(), rand_word(), 1'b1, 5'd4);
        foreach (alu_ops[i]) begin
            add_row(alu_ops[i], '0, rand_word(), rand_word(), 1'b1, 5'(i + 1));
        end
        // sign crossing compares
        add_row(cpu_pkg::OP_SLT, '0, 32'h8000_0000, 32'h0000_0001, 1'b1, 5'd4);
        add_row(cpu_pkg::OP_SLT, '0, 32'h0000_0001, 32'hffff_ffff, 1'b1, 5'd5);
        add_row(cpu_pkg::OP_SLTU, '0, 32'h8000_0000, 32'h0000_0001, 1'b1, 5'd6);
        add_row(cpu_pkg::OP_MOVN, '0, rand_word(), '0, 1'b1, 5'd8);
        add_row(cpu_pkg::OP_MOVN, '0, rand_word(), rand_word() | 32'h1, 1'b1, 5'd8);
        add_row(cpu_pkg::OP_MOVZ, '0, rand_word(), '0, 1'b1, 5'd9);
        add_row(cpu_pkg::OP_MOVZ, '0, rand_word(), 32'd5, 1'b1, 5'd9);
        // reads at distance 1 and 2 hit the mem and wb forwarding paths
        add_row(cpu_pkg::OP_MULT, '0, rand_word() | 32'h8000_0000, rand_word(), 1'b1, 5'd7);
        add_row(cpu_pkg::OP_MFHI, '0, '0, '0, 1'b1, 5'd10);
        add_row(cpu_pkg::OP_MFLO, '0, '0, '0, 1'b1, 5'd11);
        add_row(cpu_pkg::OP_MULTU, '0, rand_word() | 32'h8000_0000, rand_word(), 1'b1, 5'd7);
        add_row(cpu_pkg::OP_MFHI, '0, '0, '0, 1'b1, 5'd10);
        add_row(cpu_pkg::OP_MFLO, '0, '0, '0, 1'b1, 5'd11);
        add_row(cpu_pkg::OP_MUL, '0, rand_word(), rand_word() | 32'h8000_0000, 1'b1, 5'd12);
        add_row(cpu_pkg::OP_MTHI, '0, rand_word(), '0, 1'b1, 5'd13);
        add_row(cpu_pkg::OP_MTLO, '0, rand_word(), '0, 1'b1, 5'd14);
        add_row(cpu_pkg::OP_NOP, '0, '0, '0, 1'b0, '0);
        add_row(cpu_pkg::OP_NOP, '0, '0, '0, 1'b0, '0);
        add_row(cpu_pkg::OP_MFHI, '0, '0, '0, 1'b1, 5'd13);
        add_row(cpu_pkg::OP_MFLO, '0, '0, '0, 1'b1, 5'd14);
        // status, cause, epc read back at distance 1, 2, 3
        for (int d = 1; d <= 3; d++) begin
            add_row(cpu_pkg::OP_MTC0, '0, rand_word(),
                    32'(cpu_pkg::CP0_STATUS + d - 1), 1'b1, 5'd19);
            repeat (d - 1) add_row(cpu_pkg::OP_NOP, '0, '0, '0, 1'b0, '0);
            add_row(cpu_pkg::OP_MFC0, '0, '0, 32'(cpu_pkg::CP0_STATUS + d - 1), 1'b1, 5'(d + 14));
        end
        add_row(cpu_pkg::OP_MFC0, '0, '0, 32'd7, 1'b1, 5'd18);
        add_row(cpu_pkg::OP_LW, '0, rand_word(), rand_word(), 1'b1, 5'd20);
        add_row(cpu_pkg::OP_SW, '0, rand_word(), rand_word(), 1'b1, 5'd21);
        add_row(cpu_pkg::OP_JAL, rand_word() & ~32'h3, '0, '0, 1'b0, '0);
        add_row(cpu_pkg::OP_JALR, rand_word() & ~32'h3, '0, '0, 1'b1, 5'd22);
    endtask

    initial begin
        row_t r;
        arst_n_i     = 1'b0;
        pc_i         = '0;
        oper_i       = cpu_pkg::OP_NOP;
        reg1_i       = '0;
        reg2_i       = '0;
        wreg_write_i = 1'b0;
        wreg_addr_i  = '0;
        build_table();
        repeat (16) @(posedge clk_i);
        #2;
        arst_n_i = 1'b1;
        // row c goes in now and reaches mem one edge later and wb two
        for (int c = 0; c < rows.size() + 2; c++) begin
            @(posedge clk_i);
            #2;
            if (c >= 1) begin
                r = rows[c - 1];
                check_value("mem_oper_o", r.oper, mem_oper_o);
                if (r.oper == cpu_pkg::OP_LW || r.oper == cpu_pkg::OP_SW) begin
                    check_value("mem_addr_o", r.exp_mem_addr, mem_addr_o);
                    check_value("mem_data_o", r.exp_mem_data, mem_data_o);
                end
            end
            if (c >= 2) begin
                r = rows[c - 2];
                check_value("wb_write_o", r.exp_write, wb_write_o);
                if (r.exp_write) begin
                    check_value("wb_addr_o", r.exp_addr, wb_addr_o);
                    check_value("wb_data_o", r.exp_data, wb_data_o);
                end
            end
            if (c < rows.size()) begin
                r            = rows[c];
                pc_i         = r.pc;
                oper_i       = r.oper;
                reg1_i       = r.reg1;
                reg2_i       = r.reg2;
                wreg_write_i = r.wreg_write;
                wreg_addr_i  = r.wreg_addr;
            end else begin
                oper_i       = cpu_pkg::OP_NOP;
                wreg_write_i = 1'b0;
            end
        end
        $display("SIMULATION PASSED");
        $finish;
    end

    // reset, table and pipeline drain fit well inside this
    always @(posedge clk_i) begin
        cycles <= cycles + 1;
        if (cycles > rows.size() + 40) begin
            $display("timeout: the test table did not finish in %0d cycles", rows.size() + 40);
            $display("SIMULATION FAILED");
            $fatal(1);
        end
    end

endmodule
